//--- logic/forth_pkg.sv
// Forth core definitions

package forth_pkg;

	// One data cell and one memory word
	typedef logic [31:0] cell_t;

	// Memory address, also the return stack payload
	typedef logic [9:0] addr_t;

	// Opcodes kept from the full instruction set
	// Numbering matches the cells of the boot image
	typedef enum logic [15:0] {
		op_execute = 16'd0,
		op_exit    = 16'd10,
		op_lit     = 16'd27,
		op_branch  = 16'd56,
		op_emit    = 16'd70,
		op_io_led  = 16'd71
	} op_e;

	// Compiler access to the dictionary memory
	typedef struct packed {
		addr_t addr;
		logic  we;
		cell_t wdata;
	} mem_req_t;

	////////////////////////////////////////
	// Memory map
	localparam addr_t XTQ_START = 10'd200;
	localparam int XT_RAM_DEPTH = 32;
	localparam addr_t DICT_START = 10'd15;
	// Routine that prints "?"
	localparam cell_t ERROR_CFA = 32'd11;

	// Stack depths
	localparam int DSTACK_DEPTH = 16;
	localparam int RSTACK_DEPTH = 8;

endpackage

//--- logic/board_pkg.sv
// Board side definitions

package board_pkg;

	// Clocks per serial bit
	localparam logic [9:0] BAUD_DIV = 10'd625;

	// LEDs are active low
	typedef struct packed {
		logic r;
		logic g;
		logic b;
	} led_t;

	typedef logic [7:0] uart_byte_t;

endpackage

//--- logic/lifo_stack.sv
// Circular stack
`timescale 1ns/100ps

module lifo_stack #(
	parameter int DEPTH = 8,
	parameter type T = logic [31:0]
) (
	input logic clk,
	input logic reset,
	input logic push,
	input logic pop,
	input T wdata,
	output T top
);
	T mem [DEPTH];
	// Points at top of stack and wraps
	logic [$clog2(DEPTH)-1:0] ptr;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			ptr <= '0;
		end else if (push) begin
			ptr <= ptr + 1'b1;
		end else if (pop) begin
			ptr <= ptr - 1'b1;
		end
	end

	// Write above current top
	always_ff @(posedge clk) begin
		if (push) begin
			mem[ptr + 1'b1] <= wdata;
		end
	end

	assign top = mem[ptr];

endmodule

//--- logic/uart_rx.sv
// Serial receiver
`timescale 1ns/100ps

module uart_rx (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic rx_valid,
	output board_pkg::uart_byte_t rx_data
);
	logic [1:0] rx_sync;
	logic active;
	logic sample;
	logic [3:0] bit_cnt;
	logic [$bits(board_pkg::BAUD_DIV)-1:0] clk_cnt;

	// Mid-bit sample point
	assign sample = active && clk_cnt == '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rx_sync <= 2'b11;
			active <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx};
			rx_valid <= 1'b0;
			if (!active) begin
				// Falling edge starts the frame, wait half a bit
				if (!rx_sync[1]) begin
					active <= 1'b1;
					bit_cnt <= '0;
					clk_cnt <= (board_pkg::BAUD_DIV >> 1) - 10'd1;
				end
			end else if (sample) begin
				clk_cnt <= board_pkg::BAUD_DIV - 10'd1;
				bit_cnt <= bit_cnt + 4'd1;
				// Glitch on the start bit
				if (bit_cnt == 4'd0 && rx_sync[1]) begin
					active <= 1'b0;
				end
				// Middle of stop bit
				if (bit_cnt == 4'd9) begin
					rx_valid <= 1'b1;
					active <= 1'b0;
				end
			end else begin
				clk_cnt <= clk_cnt - 10'd1;
			end
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (sample && bit_cnt != 4'd0 && bit_cnt != 4'd9) begin
			rx_data <= {rx_sync[1], rx_data[7:1]};
		end
	end

endmodule

//--- logic/uart_tx.sv
// Serial transmitter
`timescale 1ns/100ps

module uart_tx (
	input logic clk,
	input logic reset,
	input logic tx_send,
	input board_pkg::uart_byte_t tx_data,
	output logic tx,
	output logic tx_busy
);
	// Set after a byte until tx_send drops
	logic hold;
	logic start;
	logic tick;
	logic [3:0] bit_cnt;
	logic [$bits(board_pkg::BAUD_DIV)-1:0] clk_cnt;
	// Data bits then stop bit
	logic [8:0] shift;

	assign start = tx_send && !tx_busy && !hold;
	assign tick = tx_busy && clk_cnt == '0;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			tx <= 1'b1;
			tx_busy <= 1'b0;
			hold <= 1'b0;
			bit_cnt <= '0;
			clk_cnt <= '0;
		end else if (start) begin
			// Start bit right away
			tx <= 1'b0;
			tx_busy <= 1'b1;
			hold <= 1'b1;
			bit_cnt <= '0;
			clk_cnt <= board_pkg::BAUD_DIV - 10'd1;
		end else if (!tx_busy) begin
			hold <= hold && tx_send;
		end else if (tick) begin
			clk_cnt <= board_pkg::BAUD_DIV - 10'd1;
			// End of stop bit
			if (bit_cnt == 4'd9) begin
				tx_busy <= 1'b0;
			end else begin
				tx <= shift[0];
				bit_cnt <= bit_cnt + 4'd1;
			end
		end else begin
			clk_cnt <= clk_cnt - 10'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			shift <= {1'b1, tx_data};
		end else if (tick) begin
			shift <= {1'b1, shift[8:1]};
		end
	end

	// Sequencer holds the byte for the whole frame
	data_stable: assert property (@(posedge clk) disable iff (!reset)
		tx_busy |-> $stable(tx_data));

endmodule

//--- logic/dictionary_memory.sv
// Dictionary memory
`timescale 1ns/100ps

module dictionary_memory (
	input logic clk,
	input logic reset,
	input forth_pkg::mem_req_t cmp_req,
	input logic cmp_active,
	input forth_pkg::addr_t fetch_addr,
	output forth_pkg::cell_t rdata
);
	forth_pkg::addr_t addr;
	forth_pkg::addr_t ram_off;
	logic [$clog2(forth_pkg::XT_RAM_DEPTH)-1:0] ram_idx;
	forth_pkg::cell_t rom_data;
	forth_pkg::cell_t ram [forth_pkg::XT_RAM_DEPTH];

	function automatic forth_pkg::cell_t op_cell(forth_pkg::op_e op);
		return {16'h0, op};
	endfunction

	// Call cell is the negated code field address
	function automatic forth_pkg::cell_t call_cell(forth_pkg::addr_t a);
		return -forth_pkg::cell_t'(a);
	endfunction

	// Compiler owns the port while active
	assign addr = cmp_active ? cmp_req.addr : fetch_addr;
	assign ram_off = addr - forth_pkg::XTQ_START;
	assign ram_idx = ram_off[$clog2(forth_pkg::XT_RAM_DEPTH)-1:0];

	////////////////////////////////////////
	// Boot image
	always_comb begin
		case (addr)
			// Idle loop
			10'd0: rom_data = op_cell(forth_pkg::op_execute);
			10'd1: rom_data = op_cell(forth_pkg::op_branch);
			10'd2: rom_data = 32'd0;
			// Print "?"
			10'd11: rom_data = op_cell(forth_pkg::op_lit);
			10'd12: rom_data = 32'h3f;
			10'd13: rom_data = op_cell(forth_pkg::op_emit);
			10'd14: rom_data = op_cell(forth_pkg::op_exit);
			// led
			10'd15: rom_data = 32'd19;
			10'd16: rom_data = {8'd1, "led"};
			10'd17: rom_data = op_cell(forth_pkg::op_io_led);
			10'd18: rom_data = op_cell(forth_pkg::op_exit);
			// red
			10'd19: rom_data = 32'd25;
			10'd20: rom_data = {8'd1, "red"};
			10'd21: rom_data = op_cell(forth_pkg::op_lit);
			10'd22: rom_data = 32'd4;
			10'd23: rom_data = call_cell(10'd17);
			10'd24: rom_data = op_cell(forth_pkg::op_exit);
			// green
			10'd25: rom_data = 32'd32;
			10'd26: rom_data = {8'd2, "gre"};
			10'd27: rom_data = {"en", 16'h0};
			10'd28: rom_data = op_cell(forth_pkg::op_lit);
			10'd29: rom_data = 32'd1;
			10'd30: rom_data = call_cell(10'd17);
			10'd31: rom_data = op_cell(forth_pkg::op_exit);
			// blue ends the chain
			10'd32: rom_data = 32'd0;
			10'd33: rom_data = {8'd2, "blu"};
			10'd34: rom_data = {"e", 24'h0};
			10'd35: rom_data = op_cell(forth_pkg::op_lit);
			10'd36: rom_data = 32'd2;
			10'd37: rom_data = call_cell(10'd17);
			10'd38: rom_data = op_cell(forth_pkg::op_exit);
			default: rom_data = 32'd0;
		endcase
	end

	////////////////////////////////////////
	// Token RAM
	always_ff @(posedge clk) begin
		if (cmp_active && cmp_req.we) begin
			ram[ram_idx] <= cmp_req.wdata;
		end
	end

	assign rdata = (addr < forth_pkg::XTQ_START) ? rom_data : ram[ram_idx];

	// Compiler never writes outside the token RAM
	write_in_ram: assert property (@(posedge clk) disable iff (!reset)
		cmp_active && cmp_req.we |-> cmp_req.addr >= forth_pkg::XTQ_START &&
			cmp_req.addr < forth_pkg::XTQ_START + forth_pkg::XT_RAM_DEPTH);

endmodule

//--- logic/text_interpreter.sv
// Forth outer interpreter
`timescale 1ns/100ps

module text_interpreter (
	input logic clk,
	input logic reset,
	input logic rx_valid,
	input board_pkg::uart_byte_t rx_data,
	input forth_pkg::cell_t rdata,
	input logic xt_ready,
	output forth_pkg::mem_req_t cmp_req,
	output logic cmp_active,
	output logic xt_valid
);
	typedef enum logic [2:0] {
		st_idle,
		st_link,
		st_search,
		st_number,
		st_compile,
		st_add_exit,
		st_execute
	} state_e;

	state_e state;
	// Dictionary walk pointer and next link
	forth_pkg::addr_t wp;
	forth_pkg::addr_t link;
	// Token write pointer
	forth_pkg::addr_t xtwp;
	// Word being parsed
	forth_pkg::cell_t [3:0] word_buf;
	logic [3:0] cchar;
	logic [3:0] next_char;
	logic [2:0] cells;
	logic [2:0] ccell;
	forth_pkg::cell_t name_cell;
	forth_pkg::cell_t xt;
	logic line_end;
	logic is_delim;
	logic is_digit;

	////////////////////////////////////////
	// Word helpers
	assign next_char = cchar + 4'd1;
	assign cells = {1'b0, cchar[3:2]} + 3'd1;
	// Cell count lives in the top byte of the first name cell
	assign name_cell = (ccell == 3'd0) ? {5'b0, cells, word_buf[0][23:0]} :
		word_buf[ccell[1:0]];
	// Space or line end
	assign is_delim = rx_data == " " || (rx_data >= 8'd10 && rx_data <= 8'd13);
	assign is_digit = cchar == 4'd1 && word_buf[0][23:16] inside {["0":"9"]};

	////////////////////////////////////////
	// Memory port and execute request
	assign cmp_active = state inside {st_link, st_search, st_number, st_compile, st_add_exit};
	assign xt_valid = state == st_execute;

	always_comb begin
		cmp_req.addr = (state == st_link || state == st_search) ? wp : xtwp;
		cmp_req.we = state == st_compile || state == st_add_exit ||
			(state == st_number && is_digit);
		case (state)
			st_compile: cmp_req.wdata = xt;
			st_add_exit: cmp_req.wdata = {16'h0, forth_pkg::op_exit};
			default: cmp_req.wdata = {16'h0, forth_pkg::op_lit};
		endcase
	end

	////////////////////////////////////////
	// Parse, search and compile
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state <= st_idle;
			wp <= forth_pkg::DICT_START;
			link <= '0;
			xtwp <= forth_pkg::XTQ_START;
			word_buf <= '0;
			cchar <= '0;
			ccell <= '0;
			xt <= '0;
			line_end <= 1'b0;
		end else begin
			case (state)
				st_idle: begin
					if (rx_valid && is_delim) begin
						line_end <= rx_data != " ";
						if (cchar != 4'd0) begin
							wp <= forth_pkg::DICT_START;
							state <= st_link;
						end else if (rx_data != " ") begin
							// Empty word at line end
							state <= st_add_exit;
						end
					end else if (rx_valid && cchar != 4'd15) begin
						cchar <= next_char;
						word_buf[next_char[3:2]][8 * (3 - next_char[1:0]) +: 8] <= rx_data;
					end
				end
				st_link: begin
					link <= forth_pkg::addr_t'(rdata);
					wp <= wp + 1'b1;
					ccell <= '0;
					state <= st_search;
				end
				st_search: begin
					if (ccell == cells) begin
						// wp now on the code field
						xt <= -forth_pkg::cell_t'(wp);
						state <= st_compile;
					end else if (rdata == name_cell) begin
						wp <= wp + 1'b1;
						ccell <= ccell + 3'd1;
					end else if (link != '0) begin
						wp <= link;
						state <= st_link;
					end else begin
						state <= st_number;
					end
				end
				st_number: begin
					if (is_digit) begin
						// lit already written here
						xtwp <= xtwp + 1'b1;
						xt <= {24'h0, word_buf[0][23:16] - 8'h30};
					end else begin
						xt <= -forth_pkg::ERROR_CFA;
					end
					state <= st_compile;
				end
				st_compile: begin
					xtwp <= xtwp + 1'b1;
					cchar <= '0;
					word_buf <= '0;
					state <= line_end ? st_add_exit : st_idle;
				end
				st_add_exit: state <= st_execute;
				st_execute: begin
					// Next line starts at the RAM base
					if (xt_ready) begin
						xtwp <= forth_pkg::XTQ_START;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

endmodule

//--- logic/forth_sequencer.sv
// Forth inner interpreter
`timescale 1ns/100ps

module forth_sequencer (
	input logic clk,
	input logic reset,
	input forth_pkg::cell_t rdata,
	input logic xt_valid,
	input logic tx_busy,
	input forth_pkg::cell_t ds_top,
	input forth_pkg::addr_t rs_top,
	output forth_pkg::addr_t fetch_addr,
	output logic xt_ready,
	output logic tx_send,
	output board_pkg::uart_byte_t tx_data,
	output logic ds_push,
	output logic ds_pop,
	output forth_pkg::cell_t ds_wdata,
	output logic rs_push,
	output logic rs_pop,
	output forth_pkg::addr_t rs_wdata,
	output board_pkg::led_t led
);
	// Memory pointer
	forth_pkg::addr_t mp;
	// Waiting on execute request or transmitter
	logic busy;
	// Current cell is an inline operand
	logic skip;
	forth_pkg::op_e held_op;
	forth_pkg::op_e op;
	logic decode;
	logic tx_seen;
	logic branch;
	logic advance;
	forth_pkg::addr_t branch_addr;

	assign fetch_addr = mp;
	assign decode = !busy && !skip;

	////////////////////////////////////////
	// Opcode decode and stack control
	always_comb begin
		op = forth_pkg::op_e'(rdata[15:0]);
		ds_push = 1'b0;
		ds_pop = 1'b0;
		ds_wdata = rdata;
		rs_push = 1'b0;
		rs_pop = 1'b0;
		rs_wdata = mp + 1'b1;
		xt_ready = 1'b0;
		branch = 1'b0;
		advance = 1'b0;
		branch_addr = forth_pkg::addr_t'(rdata);
		if (skip) begin
			// Inline cell of lit or branch
			if (held_op == forth_pkg::op_lit) begin
				ds_push = 1'b1;
				advance = 1'b1;
			end else begin
				branch = 1'b1;
			end
		end else if (busy) begin
			if (held_op == forth_pkg::op_execute) begin
				// Run the compiled line and come back after execute
				if (xt_valid) begin
					xt_ready = 1'b1;
					rs_push = 1'b1;
					branch = 1'b1;
					branch_addr = forth_pkg::XTQ_START;
				end
			end else begin
				// Emit done once the byte has gone out
				advance = tx_seen && !tx_busy;
			end
		end else begin
			case (op)
				forth_pkg::op_execute: ;
				forth_pkg::op_exit: begin
					rs_pop = 1'b1;
					branch = 1'b1;
					branch_addr = rs_top;
				end
				forth_pkg::op_emit: ds_pop = 1'b1;
				forth_pkg::op_io_led: begin
					ds_pop = 1'b1;
					advance = 1'b1;
				end
				forth_pkg::op_lit, forth_pkg::op_branch: advance = 1'b1;
				default: begin
					// Call by negated address
					rs_push = 1'b1;
					branch = 1'b1;
					branch_addr = forth_pkg::addr_t'(-rdata);
				end
			endcase
		end
	end

	////////////////////////////////////////
	// Pointer and flags
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			mp <= '0;
			busy <= 1'b0;
			skip <= 1'b0;
			held_op <= forth_pkg::op_execute;
			tx_send <= 1'b0;
			tx_seen <= 1'b0;
			led <= '{r: 1'b1, g: 1'b1, b: 1'b1};
		end else begin
			if (branch) begin
				mp <= branch_addr;
			end else if (advance) begin
				mp <= mp + 1'b1;
			end
			if (decode) begin
				held_op <= op;
				skip <= op == forth_pkg::op_lit || op == forth_pkg::op_branch;
				busy <= op == forth_pkg::op_execute || op == forth_pkg::op_emit;
				if (op == forth_pkg::op_emit) begin
					tx_send <= 1'b1;
				end
				// Bit 2 red, bit 0 green, bit 1 blue
				if (op == forth_pkg::op_io_led) begin
					led <= '{r: !ds_top[2], g: !ds_top[0], b: !ds_top[1]};
				end
			end else begin
				skip <= 1'b0;
				if (busy && held_op == forth_pkg::op_execute && xt_valid) begin
					busy <= 1'b0;
				end
				if (busy && held_op == forth_pkg::op_emit) begin
					if (tx_busy) begin
						tx_seen <= 1'b1;
					end
					// Busy seen high then low
					if (tx_seen && !tx_busy) begin
						busy <= 1'b0;
						tx_send <= 1'b0;
						tx_seen <= 1'b0;
					end
				end
			end
		end
	end

	// Byte to send
	always_ff @(posedge clk) begin
		if (decode && op == forth_pkg::op_emit) begin
			tx_data <= ds_top[7:0];
		end
	end

	// Stacks take one operation per cycle
	stack_one_op: assert property (@(posedge clk) disable iff (!reset)
		!(ds_push && ds_pop) && !(rs_push && rs_pop));

endmodule

//--- logic/forth_proc.sv
// Forth processor top level
`timescale 1ns/100ps

module forth_proc (
	input logic clk,
	input logic reset,
	input logic rx,
	output logic tx,
	output board_pkg::led_t led
);
	// Serial side
	logic rx_valid;
	board_pkg::uart_byte_t rx_data;
	logic tx_send;
	logic tx_busy;
	board_pkg::uart_byte_t tx_data;

	// Compiler and execute handshake
	forth_pkg::mem_req_t cmp_req;
	logic cmp_active;
	logic xt_valid;
	logic xt_ready;

	// Memory and stacks
	forth_pkg::addr_t fetch_addr;
	forth_pkg::cell_t rdata;
	logic ds_push;
	logic ds_pop;
	forth_pkg::cell_t ds_wdata;
	forth_pkg::cell_t ds_top;
	logic rs_push;
	logic rs_pop;
	forth_pkg::addr_t rs_wdata;
	forth_pkg::addr_t rs_top;

	uart_rx uart_rx_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.rx_valid(rx_valid),
		.rx_data(rx_data)
	);

	uart_tx uart_tx_i (
		.clk(clk),
		.reset(reset),
		.tx_send(tx_send),
		.tx_data(tx_data),
		.tx(tx),
		.tx_busy(tx_busy)
	);

	text_interpreter text_interpreter_i (
		.clk(clk),
		.reset(reset),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.rdata(rdata),
		.xt_ready(xt_ready),
		.cmp_req(cmp_req),
		.cmp_active(cmp_active),
		.xt_valid(xt_valid)
	);

	dictionary_memory dictionary_memory_i (
		.clk(clk),
		.reset(reset),
		.cmp_req(cmp_req),
		.cmp_active(cmp_active),
		.fetch_addr(fetch_addr),
		.rdata(rdata)
	);

	forth_sequencer forth_sequencer_i (
		.clk(clk),
		.reset(reset),
		.rdata(rdata),
		.xt_valid(xt_valid),
		.tx_busy(tx_busy),
		.ds_top(ds_top),
		.rs_top(rs_top),
		.fetch_addr(fetch_addr),
		.xt_ready(xt_ready),
		.tx_send(tx_send),
		.tx_data(tx_data),
		.ds_push(ds_push),
		.ds_pop(ds_pop),
		.ds_wdata(ds_wdata),
		.rs_push(rs_push),
		.rs_pop(rs_pop),
		.rs_wdata(rs_wdata),
		.led(led)
	);

	// Data stack
	lifo_stack #(
		.DEPTH(forth_pkg::DSTACK_DEPTH),
		.T(forth_pkg::cell_t)
	) data_stack_i (
		.clk(clk),
		.reset(reset),
		.push(ds_push),
		.pop(ds_pop),
		.wdata(ds_wdata),
		.top(ds_top)
	);

	// Return stack
	lifo_stack #(
		.DEPTH(forth_pkg::RSTACK_DEPTH),
		.T(forth_pkg::addr_t)
	) return_stack_i (
		.clk(clk),
		.reset(reset),
		.push(rs_push),
		.pop(rs_pop),
		.wdata(rs_wdata),
		.top(rs_top)
	);

endmodule

//--- tb/forth_proc_tb.sv
// Forth processor testbench
`timescale 1ns/100ps

module forth_proc_tb;
	localparam int BIT_CYCLES = int'(board_pkg::BAUD_DIV);
	localparam int CHAR_CYCLES = 10 * BIT_CYCLES;
	localparam int LINE_TIMEOUT = 40 * CHAR_CYCLES;
	localparam board_pkg::uart_byte_t CR = 8'h0d;
	localparam board_pkg::uart_byte_t LF = 8'h0a;
	// Values pushed by the color words
	localparam int RED_VALUE = 4;
	localparam int GREEN_VALUE = 1;
	localparam int BLUE_VALUE = 2;

	logic clk;
	logic reset;
	logic rx;
	logic tx;
	board_pkg::led_t led;

	// Bytes seen on tx, bytes still owed by the DUT
	board_pkg::uart_byte_t got_bytes[$];
	board_pkg::uart_byte_t exp_bytes[$];
	// Model LED state across lines
	board_pkg::led_t model_led;
	int lines_done;
	forth_pkg::addr_t last_fetch;
	logic [31:0] rand_state;
	int digit;

	// Serial monitor state
	logic mon_active;
	int mon_cnt;
	int mon_bit;
	board_pkg::uart_byte_t mon_shift;

	forth_proc forth_proc_i (
		.clk(clk),
		.reset(reset),
		.rx(rx),
		.tx(tx),
		.led(led)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	////////////////////////////////////////
	// Error handling and compares
	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_led(input board_pkg::led_t got, input board_pkg::led_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL led: expected %h, got %h", exp, got));
		end
	endtask

	task automatic check_byte(input board_pkg::uart_byte_t got,
		input board_pkg::uart_byte_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAIL tx byte: expected %h, got %h", exp, got));
		end
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	////////////////////////////////////////
	// Reference model of one line
	function automatic board_pkg::led_t expected_result(input string text,
		input board_pkg::led_t led_in, output string tx_text);
		board_pkg::led_t led_out;
		int stack[$];
		int start;
		int value;
		string w;
		led_out = led_in;
		tx_text = "";
		start = 0;
		for (int i = 0; i <= text.len(); i++) begin
			if (i == text.len() || text.getc(i) == " ") begin
				if (i > start) begin
					w = text.substr(start, i - 1);
					if (w == "red" || w == "green" || w == "blue" || w == "led") begin
						// Color words push their value, then act as led
						if (w == "red") begin
							stack.push_back(RED_VALUE);
						end else if (w == "green") begin
							stack.push_back(GREEN_VALUE);
						end else if (w == "blue") begin
							stack.push_back(BLUE_VALUE);
						end
						value = stack.pop_back();
						// A color is lit when its own value bit is set
						led_out.r = (value & RED_VALUE) == 0;
						led_out.g = (value & GREEN_VALUE) == 0;
						led_out.b = (value & BLUE_VALUE) == 0;
					end else if (w.len() == 1 && w.getc(0) >= "0" && w.getc(0) <= "9") begin
						stack.push_back(w.getc(0) - 8'h30);
					end else begin
						// Unknown word
						tx_text = {tx_text, "?"};
					end
				end
				start = i + 1;
			end
		end
		return led_out;
	endfunction

	////////////////////////////////////////
	// Serial driver
	task automatic drive_bit(input logic b);
		@(posedge clk);
		rx <= b;
		repeat (BIT_CYCLES - 1) @(posedge clk);
	endtask

	task automatic send_byte(input board_pkg::uart_byte_t data);
		drive_bit(1'b0);
		// LSB first
		for (int i = 0; i < 8; i++) begin
			drive_bit(data[i]);
		end
		drive_bit(1'b1);
		// Idle character time
		repeat (CHAR_CYCLES) @(posedge clk);
	endtask

	// Send one line, wait until it has run, then check the LEDs
	task automatic run_line(input string text, input board_pkg::uart_byte_t line_end);
		board_pkg::led_t exp_led;
		string tx_text;
		int done_before;
		int wait_cnt;
		exp_led = expected_result(text, model_led, tx_text);
		model_led = exp_led;
		for (int i = 0; i < tx_text.len(); i++) begin
			exp_bytes.push_back(tx_text.getc(i));
		end
		done_before = lines_done;
		for (int i = 0; i < text.len(); i++) begin
			send_byte(text.getc(i));
		end
		send_byte(line_end);
		wait_cnt = 0;
		@(negedge clk);
		while (lines_done <= done_before) begin
			if (wait_cnt > LINE_TIMEOUT) begin
				abort_run($sformatf("line \"%s\" never returned to the idle loop", text));
			end else begin
				wait_cnt++;
				@(negedge clk);
			end
		end
		wait_cnt = 0;
		while (exp_bytes.size() > 0) begin
			if (wait_cnt > LINE_TIMEOUT) begin
				abort_run($sformatf("expected byte on tx never arrived for \"%s\"", text));
			end else begin
				wait_cnt++;
				@(negedge clk);
			end
		end
		check_led(led, exp_led);
	endtask

	////////////////////////////////////////
	// Line done once the sequencer is back at the idle loop
	always @(negedge clk) begin
		if (forth_proc_i.fetch_addr == '0 && last_fetch != '0) begin
			lines_done++;
		end
		last_fetch = forth_proc_i.fetch_addr;
	end

	// Serial monitor sampling tx at mid-bit
	always @(negedge clk) begin
		if (!mon_active) begin
			if (tx === 1'b0) begin
				mon_active = 1'b1;
				mon_bit = 0;
				mon_cnt = BIT_CYCLES / 2;
			end
		end else begin
			mon_cnt--;
			if (mon_cnt == 0) begin
				mon_cnt = BIT_CYCLES;
				if (mon_bit == 0 && tx !== 1'b0) begin
					abort_run("start bit on tx ended too early");
				end else if (mon_bit == 9 && tx !== 1'b1) begin
					abort_run("no stop bit on tx");
				end else begin
					if (mon_bit >= 1 && mon_bit <= 8) begin
						mon_shift = {tx, mon_shift[7:1]};
					end
					if (mon_bit == 9) begin
						got_bytes.push_back(mon_shift);
						mon_active = 1'b0;
					end
					mon_bit++;
				end
			end
		end
	end

	// Received bytes against expected ones
	always @(negedge clk) begin
		if (got_bytes.size() > 0) begin
			if (exp_bytes.size() == 0) begin
				abort_run($sformatf("unexpected byte %h on tx", got_bytes[0]));
			end else begin
				check_byte(got_bytes.pop_front(), exp_bytes.pop_front());
			end
		end
	end

	////////////////////////////////////////
	// Main sequence
	initial begin
		reset = 1'b0;
		rx = 1'b1;
		lines_done = 0;
		last_fetch = '0;
		mon_active = 1'b0;
		mon_cnt = 0;
		mon_bit = 0;
		mon_shift = '0;
		model_led = '{r: 1'b1, g: 1'b1, b: 1'b1};
		rand_state = 32'h5a59_c539;
		repeat (10) @(posedge clk);
		reset <= 1'b1;

		// Idle after reset
		@(negedge clk);
		check_led(led, model_led);
		for (int i = 0; i < 2 * CHAR_CYCLES; i++) begin
			if (tx !== 1'b1) begin
				abort_run($sformatf("FAIL tx: expected %h, got %h", 1'b1, tx));
			end else begin
				@(negedge clk);
			end
		end

		// Color words
		run_line("red", CR);
		run_line("green", CR);
		run_line("blue", CR);

		// Random digits through led
		for (int n = 0; n < 6; n++) begin
			rand_state = xorshift32(rand_state);
			digit = rand_state % 10;
			run_line($sformatf("%0d led", digit), LF);
		end

		// Unknown word
		run_line("xyz", CR);

		// Several words per line
		run_line("5 blue", CR);
		run_line("q 3 led", CR);

		// Nothing more on tx
		repeat (2 * CHAR_CYCLES) @(negedge clk);
		$display("Test OK");
		$finish;
	end

endmodule

//--- forth_proc.f
logic/forth_pkg.sv
logic/board_pkg.sv
logic/lifo_stack.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/dictionary_memory.sv
logic/text_interpreter.sv
logic/forth_sequencer.sv
logic/forth_proc.sv
tb/forth_proc_tb.sv
